//--- auth_defs.svh
/* Shared widths and constants for the EV and CS authentication design.
   Included by every RTL file, and the package takes its key width from here */
`ifndef AUTH_DEFS_SVH
`define AUTH_DEFS_SVH

// ##########################################################################
// Credential widths
// ##########################################################################
`define AUTH_KEY_W 64 // Identity and public key width

// Service-provider identity, mixed into every raw identity at registration
`define AUTH_USP_ID 64'hDDDD_DDDD_DDDD_DDDD

// ##########################################################################
// Session timeout
// ##########################################################################
`define AUTH_TMO_W 24 // Timeout counter width

// About 100 ms at 125 MHz, must fit in AUTH_TMO_W bits
`define AUTH_TIMEOUT_CYCLES 12_500_000

`endif

//--- auth_pkg.sv
/* Credential and message types shared by the registrars, the two
   authentication endpoints and the top level */
`default_nettype none
`include "auth_defs.svh"

package auth_pkg;

    // Registered credential of one party
    // EV holds its pseudonym in id, CS its station identity
    typedef struct packed {
        logic [`AUTH_KEY_W-1:0] id;      // Derived identity
        logic [`AUTH_KEY_W-1:0] pub_key; // Latched public key
    } cred_t;

    // One message on the EV to CS or CS to EV path
    // Valid for exactly one cycle, no back-pressure
    typedef struct packed {
        logic  valid;
        cred_t cred;
    } auth_msg_t;

endpackage

`default_nettype wire

//--- auth_session_if.sv
/* Session control and result signals between the session controller
   and the EV and CS endpoints */
`timescale 1ns/1ps
`default_nettype none
`include "auth_defs.svh"

interface auth_session_if;

    logic start;   // Pulse, session begins
    logic abort;   // Pulse, session ends, endpoints go idle
    logic ev_ok;   // Level, EV has verified the CS
    logic ev_fail; // Pulse, EV saw a reply mismatch
    logic cs_ok;   // Level, CS has verified the EV
    logic cs_fail; // Pulse, CS saw a request mismatch

    modport ctrl (
        output start, abort,
        input  ev_ok, ev_fail, cs_ok, cs_fail
    );

    modport ev (
        input  start, abort,
        output ev_ok, ev_fail
    );

    modport cs (
        input  start, abort,
        output cs_ok, cs_fail
    );

endinterface

`default_nettype wire

//--- credential_registrar.sv
/* Two-step credential registration for one party, serving both the EV
   pseudonym and the CS station identity */
`timescale 1ns/1ps
`default_nettype none
`include "auth_defs.svh"

module credential_registrar (
    input  wire                   clk,
    input  wire                   rst,
    input  wire                   start_i,
    input  wire [`AUTH_KEY_W-1:0] raw_id_i,
    input  wire [`AUTH_KEY_W-1:0] pub_key_i,
    output auth_pkg::cred_t       cred_o,
    output logic                  registered_o
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_DERIVE,
        ST_LATCH
    } reg_state_e;

    reg_state_e state;

    // Control path, a start while busy is ignored
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state        <= ST_IDLE;
            registered_o <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (start_i) begin
                        state <= ST_DERIVE;
                    end
                end
                ST_DERIVE: begin
                    registered_o <= 1'b0; // Old credential is being replaced
                    state        <= ST_LATCH;
                end
                ST_LATCH: begin
                    registered_o <= 1'b1;
                    state        <= ST_IDLE;
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // Credential payload, identity first and key one cycle later
    always_ff @(posedge clk) begin
        if (state == ST_DERIVE) begin
            cred_o.id <= raw_id_i ^ `AUTH_USP_ID;
        end
        if (state == ST_LATCH) begin
            cred_o.pub_key <= pub_key_i;
        end
    end

endmodule

`default_nettype wire

//--- ev_authenticator.sv
/* EV endpoint: sends its own credential as the request once a session starts,
   then checks the CS reply against the station credential known from registration */
`timescale 1ns/1ps
`default_nettype none
`include "auth_defs.svh"

module ev_authenticator (
    input  wire                 clk,
    input  wire                 rst,
    auth_session_if.ev          sess,
    input  wire                 registered_i,
    input  wire auth_pkg::cred_t     self_cred_i,
    input  wire auth_pkg::cred_t     known_cs_i,
    input  wire auth_pkg::auth_msg_t rx_msg_i,
    output auth_pkg::auth_msg_t tx_msg_o
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_SEND,
        ST_WAIT_REPLY,
        ST_DONE
    } ev_state_e;

    ev_state_e       state;
    logic            tx_valid;
    auth_pkg::cred_t tx_cred;
    logic            reply_match;
    logic            send_now;

    // Both the identity and the key must equal the known CS values
    assign reply_match = (rx_msg_i.cred.id == known_cs_i.id) &&
                         (rx_msg_i.cred.pub_key == known_cs_i.pub_key);
    assign send_now    = (state == ST_SEND) && registered_i;

    // ######################################################################
    // EV FSM
    // ######################################################################
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state        <= ST_IDLE;
            tx_valid     <= 1'b0;
            sess.ev_ok   <= 1'b0;
            sess.ev_fail <= 1'b0;
        end else begin
            tx_valid     <= 1'b0;
            sess.ev_fail <= 1'b0;

            if (sess.abort) begin
                state      <= ST_IDLE;
                sess.ev_ok <= 1'b0;
            end else begin
                case (state)
                    ST_IDLE: begin
                        if (sess.start) begin
                            state <= ST_SEND;
                        end
                    end
                    ST_SEND: begin
                        // Unregistered EV stays here until abort
                        if (registered_i) begin
                            tx_valid <= 1'b1;
                            state    <= ST_WAIT_REPLY;
                        end
                    end
                    ST_WAIT_REPLY: begin
                        if (rx_msg_i.valid) begin
                            sess.ev_ok   <= reply_match;
                            sess.ev_fail <= !reply_match;
                            state        <= ST_DONE;
                        end
                    end
                    default: begin
                        state <= ST_DONE; // Hold the result until abort
                    end
                endcase
            end
        end
    end

    // Request payload
    always_ff @(posedge clk) begin
        if (send_now) begin
            tx_cred <= self_cred_i;
        end
    end

    assign tx_msg_o.valid = tx_valid;
    assign tx_msg_o.cred  = tx_cred;

endmodule

`default_nettype wire

//--- cs_authenticator.sv
/* CS endpoint: waits for the EV request, checks it against the EV credential
   known from registration and answers a match with its own credential */
`timescale 1ns/1ps
`default_nettype none
`include "auth_defs.svh"

module cs_authenticator (
    input  wire                 clk,
    input  wire                 rst,
    auth_session_if.cs          sess,
    input  wire auth_pkg::cred_t     self_cred_i,
    input  wire auth_pkg::cred_t     known_ev_i,
    input  wire auth_pkg::auth_msg_t rx_msg_i,
    output auth_pkg::auth_msg_t tx_msg_o
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WAIT_REQ,
        ST_DONE
    } cs_state_e;

    cs_state_e       state;
    logic            tx_valid;
    auth_pkg::cred_t tx_cred;
    logic            req_match;
    logic            reply_now;

    assign req_match = (rx_msg_i.cred.id == known_ev_i.id) &&
                       (rx_msg_i.cred.pub_key == known_ev_i.pub_key);
    assign reply_now = (state == ST_WAIT_REQ) && rx_msg_i.valid && req_match;

    // ######################################################################
    // CS FSM
    // ######################################################################
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state        <= ST_IDLE;
            tx_valid     <= 1'b0;
            sess.cs_ok   <= 1'b0;
            sess.cs_fail <= 1'b0;
        end else begin
            tx_valid     <= 1'b0;
            sess.cs_fail <= 1'b0;

            if (sess.abort) begin
                state      <= ST_IDLE;
                sess.cs_ok <= 1'b0;
            end else begin
                case (state)
                    ST_IDLE: begin
                        if (sess.start) begin
                            state <= ST_WAIT_REQ;
                        end
                    end
                    ST_WAIT_REQ: begin
                        // Verified in the cycle the request is valid
                        if (rx_msg_i.valid) begin
                            sess.cs_ok   <= req_match;
                            sess.cs_fail <= !req_match;
                            tx_valid     <= req_match; // Reply only on a match
                            state        <= ST_DONE;
                        end
                    end
                    default: begin
                        state <= ST_DONE;
                    end
                endcase
            end
        end
    end

    // Reply payload
    always_ff @(posedge clk) begin
        if (reply_now) begin
            tx_cred <= self_cred_i;
        end
    end

    assign tx_msg_o.valid = tx_valid;
    assign tx_msg_o.cred  = tx_cred;

endmodule

`default_nettype wire

//--- auth_session_ctrl.sv
/* Session controller: accepts authentication starts, runs the timeout counter,
   pulses abort at the end of a session and holds the result flags */
`timescale 1ns/1ps
`default_nettype none
`include "auth_defs.svh"

module auth_session_ctrl #(
    parameter int unsigned TIMEOUT_CYCLES = `AUTH_TIMEOUT_CYCLES
) (
    input  wire          clk,
    input  wire          rst,
    input  wire          start_auth_i,
    auth_session_if.ctrl sess,
    output logic         active_o,
    output logic         mutual_o,
    output logic         fail_o,
    output logic         ev_auth_o,
    output logic         cs_auth_o
);

    // Count value on the last cycle of an active session
    localparam logic [`AUTH_TMO_W-1:0] TMO_LAST = (`AUTH_TMO_W)'(TIMEOUT_CYCLES - 1);

    logic [`AUTH_TMO_W-1:0] tmo_cnt;
    logic                   both_ok;
    logic                   any_fail;
    logic                   timed_out;

    assign both_ok   = sess.ev_ok && sess.cs_ok;
    assign any_fail  = sess.ev_fail || sess.cs_fail; // Either side saw a mismatch
    assign timed_out = (tmo_cnt == TMO_LAST);

    // ######################################################################
    // Session FSM, one active flag plus the latched results
    // ######################################################################
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            active_o   <= 1'b0;
            tmo_cnt    <= '0;
            sess.start <= 1'b0;
            sess.abort <= 1'b0;
            mutual_o   <= 1'b0;
            fail_o     <= 1'b0;
            ev_auth_o  <= 1'b0;
            cs_auth_o  <= 1'b0;
        end else begin
            sess.start <= 1'b0; // Both are single-cycle pulses
            sess.abort <= 1'b0;

            if (!active_o) begin
                if (start_auth_i) begin
                    active_o   <= 1'b1;
                    sess.start <= 1'b1;
                    tmo_cnt    <= '0;
                    mutual_o   <= 1'b0; // Previous results cleared here
                    fail_o     <= 1'b0;
                    ev_auth_o  <= 1'b0;
                    cs_auth_o  <= 1'b0;
                end
            end else if (both_ok || any_fail || timed_out) begin
                // Success takes priority when it lands with the timeout
                active_o   <= 1'b0;
                sess.abort <= 1'b1;
                mutual_o   <= both_ok;
                fail_o     <= !both_ok;
                ev_auth_o  <= sess.ev_ok;
                cs_auth_o  <= sess.cs_ok;
            end else begin
                tmo_cnt <= tmo_cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- auth_top.sv
/* Top level of the EV and CS registration and mutual authentication design.
   Raw identities and keys must stay stable while a registration runs */
`timescale 1ns/1ps
`default_nettype none
`include "auth_defs.svh"

module auth_top #(
    parameter int unsigned TIMEOUT_CYCLES = `AUTH_TIMEOUT_CYCLES
) (
    input  wire                   clk,
    input  wire                   rst,
    input  wire                   start_reg_ev_i,
    input  wire                   start_reg_cs_i,
    input  wire                   start_auth_i,
    input  wire [`AUTH_KEY_W-1:0] ev_raw_id_i,
    input  wire [`AUTH_KEY_W-1:0] ev_pub_key_i,
    input  wire [`AUTH_KEY_W-1:0] cs_raw_id_i,
    input  wire [`AUTH_KEY_W-1:0] cs_pub_key_i,
    output logic                  ev_reg_o,
    output logic                  cs_reg_o,
    output logic                  ev_auth_o,
    output logic                  cs_auth_o,
    output logic                  mutual_auth_o,
    output logic                  auth_fail_o,
    output logic                  auth_active_o
);

    auth_pkg::cred_t     ev_cred;
    auth_pkg::cred_t     cs_cred;
    auth_pkg::auth_msg_t ev_to_cs;  // Request path
    auth_pkg::auth_msg_t cs_to_ev;  // Reply path

    auth_session_if sess_if ();

    // ######################################################################
    // Registration
    // ######################################################################
    credential_registrar u_ev_reg (
        .clk          (clk),
        .rst          (rst),
        .start_i      (start_reg_ev_i),
        .raw_id_i     (ev_raw_id_i),
        .pub_key_i    (ev_pub_key_i),
        .cred_o       (ev_cred),
        .registered_o (ev_reg_o)
    );

    credential_registrar u_cs_reg (
        .clk          (clk),
        .rst          (rst),
        .start_i      (start_reg_cs_i),
        .raw_id_i     (cs_raw_id_i),
        .pub_key_i    (cs_pub_key_i),
        .cred_o       (cs_cred),
        .registered_o (cs_reg_o)
    );

    // ######################################################################
    // Authentication endpoints and session control
    // ######################################################################
    ev_authenticator u_ev_auth (
        .clk          (clk),
        .rst          (rst),
        .sess         (sess_if.ev),
        .registered_i (ev_reg_o),
        .self_cred_i  (ev_cred),
        .known_cs_i   (cs_cred),
        .rx_msg_i     (cs_to_ev),
        .tx_msg_o     (ev_to_cs)
    );

    cs_authenticator u_cs_auth (
        .clk          (clk),
        .rst          (rst),
        .sess         (sess_if.cs),
        .self_cred_i  (cs_cred),
        .known_ev_i   (ev_cred),
        .rx_msg_i     (ev_to_cs),
        .tx_msg_o     (cs_to_ev)
    );

    auth_session_ctrl #(
        .TIMEOUT_CYCLES (TIMEOUT_CYCLES)
    ) u_ctrl (
        .clk          (clk),
        .rst          (rst),
        .start_auth_i (start_auth_i),
        .sess         (sess_if.ctrl),
        .active_o     (auth_active_o),
        .mutual_o     (mutual_auth_o),
        .fail_o       (auth_fail_o),
        .ev_auth_o    (ev_auth_o),
        .cs_auth_o    (cs_auth_o)
    );

endmodule

`default_nettype wire

//--- tb_auth_top.sv
/* Table-driven testbench for auth_top. Runs registration and authentication
   steps in order and checks the status outputs after each one */
`timescale 1ns/1ps
`default_nettype none
`include "auth_defs.svh"

module tb_auth_top;

    localparam int TMO_CYCLES = 64;
    localparam int REG_LIMIT  = 8;  // Cycles allowed for one registration
    localparam int NUM_ROWS   = 7;

    typedef enum logic [1:0] {
        ACT_REG_EV,
        ACT_REG_CS,
        ACT_AUTH
    } action_e;

    // Flag order in exp_flags is ev_reg, cs_reg, mutual, fail, ev_auth, cs_auth
    typedef struct {
        action_e                act;
        logic                   extra_start; // Second start pulse mid-session
        logic [`AUTH_KEY_W-1:0] raw_id;
        logic [`AUTH_KEY_W-1:0] pub_key;
        logic [5:0]             exp_flags;
    } step_t;

    logic                   clk;
    logic                   rst;
    logic                   start_reg_ev;
    logic                   start_reg_cs;
    logic                   start_auth;
    logic [`AUTH_KEY_W-1:0] ev_raw_id;
    logic [`AUTH_KEY_W-1:0] ev_pub_key;
    logic [`AUTH_KEY_W-1:0] cs_raw_id;
    logic [`AUTH_KEY_W-1:0] cs_pub_key;
    logic                   ev_reg;
    logic                   cs_reg;
    logic                   ev_auth;
    logic                   cs_auth;
    logic                   mutual_auth;
    logic                   auth_fail;
    logic                   auth_active;

    step_t       steps [NUM_ROWS];
    logic [15:0] lfsr_state;
    int          err_count;
    int          tmo_count;
    int          row;

    auth_top #(
        .TIMEOUT_CYCLES (TMO_CYCLES)
    ) UUT (
        .clk            (clk),
        .rst            (rst),
        .start_reg_ev_i (start_reg_ev),
        .start_reg_cs_i (start_reg_cs),
        .start_auth_i   (start_auth),
        .ev_raw_id_i    (ev_raw_id),
        .ev_pub_key_i   (ev_pub_key),
        .cs_raw_id_i    (cs_raw_id),
        .cs_pub_key_i   (cs_pub_key),
        .ev_reg_o       (ev_reg),
        .cs_reg_o       (cs_reg),
        .ev_auth_o      (ev_auth),
        .cs_auth_o      (cs_auth),
        .mutual_auth_o  (mutual_auth),
        .auth_fail_o    (auth_fail),
        .auth_active_o  (auth_active)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk; // 40 ns period
    end

    // ######################################################################
    // Random values and the stimulus table
    // ######################################################################
    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [`AUTH_KEY_W-1:0] random_word();
        logic [`AUTH_KEY_W-1:0] w;
        w = '0;
        for (int b = 0; b < `AUTH_KEY_W; b++) begin
            lfsr_state = lfsr_step(lfsr_state); // One step per bit
            w = {w[`AUTH_KEY_W-2:0], lfsr_state[0]};
        end
        return w;
    endfunction

    task automatic set_step(input int idx, input action_e act, input logic extra,
                            input logic [5:0] flags);
        steps[idx].act         = act;
        steps[idx].extra_start = extra;
        steps[idx].raw_id      = random_word();
        steps[idx].pub_key     = random_word();
        steps[idx].exp_flags   = flags;
    endtask

    task automatic build_table();
        set_step(0, ACT_REG_CS, 1'b0, 6'b010000);
        set_step(1, ACT_AUTH,   1'b0, 6'b010100); // Only CS registered so it times out
        set_step(2, ACT_REG_EV, 1'b0, 6'b110100); // Old result still held
        set_step(3, ACT_AUTH,   1'b0, 6'b111011);
        set_step(4, ACT_REG_EV, 1'b0, 6'b111011); // New EV identity and key
        set_step(5, ACT_AUTH,   1'b0, 6'b111011);
        set_step(6, ACT_AUTH,   1'b1, 6'b111011);
    endtask

    // ######################################################################
    // Checks
    // ######################################################################
    task automatic check_bit(input string what, input logic got, input logic exp_val);
        assert (got === exp_val) else begin
            err_count++;
            $display("[ERROR] %0d ns: %s is %b, expected %b", $time, what, got, exp_val);
        end
    endtask

    task automatic check_int(input string what, input int got, input int exp_val);
        assert (got == exp_val) else begin
            err_count++;
            $display("[ERROR] %0d ns: %s is %0d, expected %0d", $time, what, got, exp_val);
        end
    endtask

    task automatic check_flags(input logic [5:0] flags);
        check_bit("ev_reg_o", ev_reg, flags[5]);
        check_bit("cs_reg_o", cs_reg, flags[4]);
        check_bit("mutual_auth_o", mutual_auth, flags[3]);
        check_bit("auth_fail_o", auth_fail, flags[2]);
        check_bit("ev_auth_o", ev_auth, flags[1]);
        check_bit("cs_auth_o", cs_auth, flags[0]);
    endtask

    // ######################################################################
    // Step drivers enter and leave 1 ns after a rising edge
    // ######################################################################
    task automatic register_party(input step_t s);
        int   cycles;
        logic is_ev;
        logic own;
        logic other;
        is_ev = (s.act == ACT_REG_EV);
        if (is_ev) begin
            ev_raw_id    = s.raw_id;
            ev_pub_key   = s.pub_key;
            start_reg_ev = 1'b1;
        end else begin
            cs_raw_id    = s.raw_id;
            cs_pub_key   = s.pub_key;
            start_reg_cs = 1'b1;
        end
        @(posedge clk); // Start sampled here
        #1;
        start_reg_ev = 1'b0;
        start_reg_cs = 1'b0;
        cycles = 0;
        do begin
            @(posedge clk);
            #1;
            cycles++;
            own   = is_ev ? ev_reg : cs_reg;
            other = is_ev ? cs_reg : ev_reg;
            check_bit("other party registered flag", other,
                      is_ev ? s.exp_flags[4] : s.exp_flags[5]);
            if (cycles == 1)
                check_bit("registered flag one cycle after start", own, 1'b0);
        end while (!own && cycles < REG_LIMIT);
        if (!own) begin
            tmo_count++;
            $display("Timeout: registration did not finish within %0d cycles", REG_LIMIT);
        end else begin
            check_int("registration latency", cycles, 2);
        end
    endtask

    task automatic run_session(input step_t s);
        int cycles;
        start_auth = 1'b1;
        @(posedge clk);
        #1;
        start_auth = 1'b0;
        // Accepted with the last session's results cleared
        check_bit("auth_active_o at session start", auth_active, 1'b1);
        check_bit("mutual_auth_o at session start", mutual_auth, 1'b0);
        check_bit("auth_fail_o at session start", auth_fail, 1'b0);
        check_bit("ev_auth_o at session start", ev_auth, 1'b0);
        check_bit("cs_auth_o at session start", cs_auth, 1'b0);
        start_auth = s.extra_start; // Lands while the session is active
        cycles = 0;
        do begin
            @(posedge clk);
            #1;
            start_auth = 1'b0;
            cycles++;
        end while (auth_active && cycles <= TMO_CYCLES + 8);
        if (auth_active) begin
            tmo_count++;
            $display("Timeout: session did not end within %0d cycles", TMO_CYCLES + 8);
        end else begin
            if (s.exp_flags[2]) begin
                check_int("session length on timeout", cycles, TMO_CYCLES);
            end else begin
                assert (cycles < TMO_CYCLES) else begin
                    err_count++;
                    $display("[ERROR] %0d ns: session took %0d cycles, expected fewer than %0d",
                             $time, cycles, TMO_CYCLES);
                end
            end
            @(posedge clk);
            #1;
            check_bit("auth_active_o after the session", auth_active, 1'b0);
        end
    endtask

    // ######################################################################
    // Main sequence
    // ######################################################################
    initial begin
        rst          = 1'b1;
        start_reg_ev = 1'b0;
        start_reg_cs = 1'b0;
        start_auth   = 1'b0;
        ev_raw_id    = '0;
        ev_pub_key   = '0;
        cs_raw_id    = '0;
        cs_pub_key   = '0;
        err_count    = 0;
        tmo_count    = 0;
        lfsr_state   = 16'd94;
        build_table();

        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;
        check_flags(6'b000000);
        check_bit("auth_active_o after reset", auth_active, 1'b0);

        for (row = 0; row < NUM_ROWS && tmo_count == 0; row++) begin
            if (steps[row].act == ACT_AUTH)
                run_session(steps[row]);
            else
                register_party(steps[row]);
            if (tmo_count == 0)
                check_flags(steps[row].exp_flags);
        end

        $display("Checks done: %0d errors, %0d timeouts", err_count, tmo_count);
        if (err_count == 0 && tmo_count == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
+incdir+.
auth_pkg.sv
auth_session_if.sv
credential_registrar.sv
ev_authenticator.sv
cs_authenticator.sv
auth_session_ctrl.sv
auth_top.sv
tb_auth_top.sv

//--- Makefile
# Verilator build and run of the EV and CS authentication testbench

BIN  := obj_dir/Vtb_auth_top
SRCS := auth_defs.svh auth_pkg.sv auth_session_if.sv credential_registrar.sv \
        ev_authenticator.sv cs_authenticator.sv auth_session_ctrl.sv auth_top.sv \
        tb_auth_top.sv

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): flist.f $(SRCS)
	verilator --binary --timing --assert -f flist.f --top-module tb_auth_top -Mdir obj_dir

run: $(BIN)
	./$(BIN) > sim.log 2>&1 || true
	cat sim.log
	! grep -q "Simulation FAILED" sim.log
	grep -q "Simulation PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
